// File: Bender.yml
package:
  name: mips_decode

sources:
  - mipsPkg.sv
  - instrDecoder.sv
  - branchCompare.sv
  - regFile.sv
  - nextPcUnit.sv
  - idStage.sv
  - decodeTop.sv
  - target: test
    files:
      - tbDecodeTop.sv

// File: branchCompare.sv
`timescale 1ns/1ps

module branchCompare import mipsPkg::*; (
    input  instrT       instr,
    input  logic [31:0] dataRs,
    input  logic [31:0] dataRt,
    output logic        cmp
);

    always_comb begin
        case (instr)
            iBeq:            cmp = (dataRs == dataRt);
            iBne:            cmp = (dataRs != dataRt);
            iBgez, iBgezal:  cmp = !dataRs[31];
            iBltz, iBltzal:  cmp = dataRs[31];
            iBgtz:           cmp = !dataRs[31] && (dataRs != 32'd0);
            iBlez:           cmp = dataRs[31] || (dataRs == 32'd0);
            // Conditional moves test rt
            iMovz:           cmp = (dataRt == 32'd0);
            iMovn:           cmp = (dataRt != 32'd0);
            default:         cmp = 1'b0;
        endcase
    end

    // Compare table must agree with the class table in the package
    cmpOnlyConditional: assert final (
        !cmp || instrClassOf(instr) == branch || instr inside {iMovz, iMovn}
    ) else $error("cmp set for non-conditional instr %s", instr.name());

endmodule

// File: decodeTop.sv
`timescale 1ns/1ps

module decodeTop import mipsPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              stall,
    input  logic              flush,
    input  instrWordT         code,
    input  fwdT               fwdEx,
    input  fwdT               fwdMem,
    input  logic              wbEn,
    input  logic [4:0]        wbAddr,
    input  logic [31:0]       wbData,
    input  logic [tWidth-1:0] tNewIn,
    output logic [31:0]       pcIf,
    output idExT              idEx
);

    logic [31:0] pcId;
    logic [4:0]  ra1;
    logic [4:0]  ra2;
    logic [31:0] rd1;
    logic [31:0] rd2;
    instrT       instr;
    logic        cmp;
    logic [15:0] imm16;
    logic [25:0] jIndex;
    logic [31:0] jmpReg;
    logic        excAdEL;

    regFile uRegFile (
        .clk  (clk),
        .rstN (rstN),
        .ra1  (ra1),
        .ra2  (ra2),
        .wa   (wbAddr),
        .we   (wbEn),
        .wd   (wbData),
        .rd1  (rd1),
        .rd2  (rd2)
    );

    nextPcUnit uNextPc (
        .clk     (clk),
        .rstN    (rstN),
        .stall   (stall),
        .instr   (instr),
        .cmp     (cmp),
        .imm16   (imm16),
        .jIndex  (jIndex),
        .jmpReg  (jmpReg),
        .pcIf    (pcIf),
        .pcId    (pcId),
        .excAdEL (excAdEL)
    );

    idStage uIdStage (
        .clk     (clk),
        .rstN    (rstN),
        .stall   (stall),
        .flush   (flush),
        .code    (code),
        .pcId    (pcId),
        .fwdEx   (fwdEx),
        .fwdMem  (fwdMem),
        .rd1     (rd1),
        .rd2     (rd2),
        .tNewIn  (tNewIn),
        .excAdEL (excAdEL),
        .ra1     (ra1),
        .ra2     (ra2),
        .instr   (instr),
        .cmp     (cmp),
        .imm16   (imm16),
        .jIndex  (jIndex),
        .jmpReg  (jmpReg),
        .idEx    (idEx)
    );

endmodule

// File: idStage.sv
`timescale 1ns/1ps

module idStage import mipsPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              stall,
    input  logic              flush,
    input  instrWordT         code,
    input  logic [31:0]       pcId,
    input  fwdT               fwdEx,
    input  fwdT               fwdMem,
    input  logic [31:0]       rd1,
    input  logic [31:0]       rd2,
    input  logic [tWidth-1:0] tNewIn,
    input  logic              excAdEL,
    output logic [4:0]        ra1,
    output logic [4:0]        ra2,
    output instrT             instr,
    output logic              cmp,
    output logic [15:0]       imm16,
    output logic [25:0]       jIndex,
    output logic [31:0]       jmpReg,
    output idExT              idEx
);

    logic [4:0]        addrRs;
    logic [4:0]        addrRt;
    logic [4:0]        addrRd;
    logic [4:0]        shamt;
    logic              excRi;
    logic [31:0]       dataRs;
    logic [31:0]       dataRt;
    logic [4:0]        wbAddr;
    logic [31:0]       wbData;
    logic [tWidth-1:0] tNew;
    instrClassT        instrClass;
    idExT              idExNext;

    // EX beats MEM beats the register file
    function automatic logic [31:0] forwardOperand(
        logic [4:0] addr, fwdT ex, fwdT mem, logic [31:0] regData);
        if (ex.addr != 5'd0 && ex.addr == addr)
            return ex.data;
        if (mem.addr != 5'd0 && mem.addr == addr)
            return mem.data;
        return regData;
    endfunction

    instrDecoder uDecoder (
        .code   (code),
        .instr  (instr),
        .rs     (addrRs),
        .rt     (addrRt),
        .rd     (addrRd),
        .shamt  (shamt),
        .imm16  (imm16),
        .jIndex (jIndex),
        .excRi  (excRi)
    );

    assign ra1    = addrRs;
    assign ra2    = addrRt;
    assign dataRs = forwardOperand(addrRs, fwdEx, fwdMem, rd1);
    assign dataRt = forwardOperand(addrRt, fwdEx, fwdMem, rd2);
    assign jmpReg = dataRs;

    branchCompare uCompare (
        .instr  (instr),
        .dataRs (dataRs),
        .dataRt (dataRt),
        .cmp    (cmp)
    );

    assign instrClass = instrClassOf(instr);
    assign tNew       = (tNewIn != '0) ? tNewIn - 1'b1 : '0;

    // Destination register, link only when the branch is taken
    always_comb begin
        if (instr == iJal)
            wbAddr = regLink;
        else if (instr == iBgezal || instr == iBltzal)
            wbAddr = cmp ? regLink : 5'd0;
        else if (instr == iMovz || instr == iMovn)
            wbAddr = cmp ? addrRd : 5'd0;
        else if (instrClass == calcR || instr inside {iJalr, iMfhi, iMflo})
            wbAddr = addrRd;
        else if (instrClass == calcI || instrClass == memRead)
            wbAddr = addrRt;
        else
            wbAddr = 5'd0;
    end

    // Values already known in decode
    always_comb begin
        if (instr inside {iJal, iJalr, iBgezal, iBltzal})
            wbData = pcId + 32'd8;
        else if (instr == iLui)
            wbData = {imm16, 16'h0000};
        else if ((instr == iMovz || instr == iMovn) && cmp)
            wbData = dataRs;
        else
            wbData = 32'd0;
    end

    always_comb begin
        idExNext.instr  = instr;
        idExNext.pc     = pcId;
        // The port name hides the enum literal, hence the package scope
        if (excRi)
            idExNext.exc = excRI;
        else if (excAdEL)
            idExNext.exc = mipsPkg::excAdEL;
        else
            idExNext.exc = excNone;
        idExNext.dataRs = dataRs;
        idExNext.dataRt = dataRt;
        idExNext.imm16  = imm16;
        idExNext.shamt  = shamt;
        idExNext.addrRs = addrRs;
        idExNext.addrRt = addrRt;
        idExNext.addrRd = addrRd;
        idExNext.wbAddr = wbAddr;
        idExNext.wbData = wbData;
        idExNext.tNew   = tNew;
    end

    // Flush takes priority over stall
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            idEx <= '0;
        end else if (!stall) begin
            idEx <= idExNext;
        end
    end

    flushGivesNop: assert property (
        @(posedge clk) flush |=> (idEx.instr == iNop && idEx.exc == excNone)
    ) else $error("idEx not cleared after flush");

endmodule

// File: instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import mipsPkg::*; (
    input  instrWordT   code,
    output instrT       instr,
    output logic [4:0]  rs,
    output logic [4:0]  rt,
    output logic [4:0]  rd,
    output logic [4:0]  shamt,
    output logic [15:0] imm16,
    output logic [25:0] jIndex,
    output logic        excRi
);

    // Operand fields straight from the two layouts
    assign rs     = code.rView.rs;
    assign rt     = code.rView.rt;
    assign rd     = code.rView.rd;
    assign shamt  = code.rView.shamt;
    assign imm16  = code.iView.imm16;
    assign jIndex = code.rView[25:0];

    always_comb begin
        instr = iNop;
        case (code.rView.opcode)
            // SPECIAL2
            6'b011100: begin
                case (code.rView.funct)
                    6'b100001: instr = iClo;
                    6'b100000: instr = iClz;
                    6'b000000: instr = iMadd;
                    6'b000001: instr = iMaddu;
                    6'b000100: instr = iMsub;
                    6'b000101: instr = iMsubu;
                    default:   instr = iNop;
                endcase
            end
            // REGIMM, rt picks the branch
            6'b000001: begin
                case (code.iView.rt)
                    5'b00001: instr = iBgez;
                    5'b00000: instr = iBltz;
                    5'b10001: instr = iBgezal;
                    5'b10000: instr = iBltzal;
                    default:  instr = iNop;
                endcase
            end
            // COP0
            6'b010000: begin
                if (code.rView.rs == 5'b00000)
                    instr = iMfc0;
                else if (code.rView.rs == 5'b00100)
                    instr = iMtc0;
                else if (code.rView.funct == 6'b011000)
                    instr = iEret;
            end
            // SPECIAL, funct table
            6'b000000: begin
                case (code.rView.funct)
                    6'b100000: instr = iAdd;
                    6'b100010: instr = iSub;
                    6'b100001: instr = iAddu;
                    6'b100011: instr = iSubu;
                    6'b100100: instr = iAnd;
                    6'b100101: instr = iOr;
                    6'b100110: instr = iXor;
                    6'b100111: instr = iNor;
                    6'b101010: instr = iSlt;
                    6'b101011: instr = iSltu;
                    6'b000000: instr = iSll;
                    6'b000100: instr = iSllv;
                    6'b000010: instr = iSrl;
                    6'b000110: instr = iSrlv;
                    6'b000011: instr = iSra;
                    6'b000111: instr = iSrav;
                    6'b001001: instr = iJalr;
                    6'b001000: instr = iJr;
                    6'b011000: instr = iMult;
                    6'b011001: instr = iMultu;
                    6'b011010: instr = iDiv;
                    6'b011011: instr = iDivu;
                    6'b010000: instr = iMfhi;
                    6'b010010: instr = iMflo;
                    6'b010001: instr = iMthi;
                    6'b010011: instr = iMtlo;
                    6'b001010: instr = iMovz;
                    6'b001011: instr = iMovn;
                    default:   instr = iNop;
                endcase
            end
            default: begin
                case (code.rView.opcode)
                    6'b001000: instr = iAddi;
                    6'b001001: instr = iAddiu;
                    6'b001100: instr = iAndi;
                    6'b001101: instr = iOri;
                    6'b001110: instr = iXori;
                    6'b001111: instr = iLui;
                    6'b001010: instr = iSlti;
                    6'b001011: instr = iSltiu;
                    6'b100011: instr = iLw;
                    6'b100001: instr = iLh;
                    6'b100101: instr = iLhu;
                    6'b100000: instr = iLb;
                    6'b100100: instr = iLbu;
                    6'b101011: instr = iSw;
                    6'b101001: instr = iSh;
                    6'b101000: instr = iSb;
                    6'b000100: instr = iBeq;
                    6'b000101: instr = iBne;
                    6'b000110: instr = iBlez;
                    6'b000111: instr = iBgtz;
                    6'b000010: instr = iJ;
                    6'b000011: instr = iJal;
                    default:   instr = iNop;
                endcase
            end
        endcase
        // All-zero word would read as SLL, it is the canonical NOP
        if (code == 32'd0)
            instr = iNop;
    end

    assign excRi = (code != 32'd0) && (instr == iNop);

endmodule

// File: mipsPkg.sv
package mipsPkg;

    // Link register and fetch address after reset
    localparam logic [4:0]  regLink = 5'd31;
    localparam logic [31:0] resetPc = 32'h0000_3000;
    localparam int          tWidth  = 2;

    // One symbol per supported instruction, NOP must stay at zero
    typedef enum logic [5:0] {
        iNop,
        iAdd, iSub, iAddu, iSubu, iAnd, iOr, iXor, iNor, iSlt, iSltu,
        iSll, iSllv, iSrl, iSrlv, iSra, iSrav,
        iJalr, iJr,
        iMult, iMultu, iDiv, iDivu, iMfhi, iMflo, iMthi, iMtlo,
        iMovz, iMovn,
        iAddi, iAddiu, iAndi, iOri, iXori, iLui, iSlti, iSltiu,
        iLw, iLh, iLhu, iLb, iLbu,
        iSw, iSh, iSb,
        iBeq, iBne, iBlez, iBgtz,
        iJ, iJal,
        iBgez, iBltz, iBgezal, iBltzal,
        iClo, iClz, iMadd, iMaddu, iMsub, iMsubu,
        iMfc0, iMtc0, iEret
    } instrT;

    // Register-format layout
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rViewT;

    // Immediate-format layout
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iViewT;

    typedef union packed {
        rViewT rView;
        iViewT iView;
    } instrWordT;

    typedef enum logic [4:0] {
        excNone = 5'd0,
        excAdEL = 5'd4,
        excRI   = 5'd10
    } excCodeT;

    typedef enum logic [2:0] {
        calcR, calcI, memRead, memWrite, branch, jump, other
    } instrClassT;

    // Payload handed from decode to execute
    typedef struct packed {
        instrT             instr;
        logic [31:0]       pc;
        excCodeT           exc;
        logic [31:0]       dataRs;
        logic [31:0]       dataRt;
        logic [15:0]       imm16;
        logic [4:0]        shamt;
        logic [4:0]        addrRs;
        logic [4:0]        addrRt;
        logic [4:0]        addrRd;
        logic [4:0]        wbAddr;
        logic [31:0]       wbData;
        logic [tWidth-1:0] tNew;
    } idExT;

    // One forwarding source, address 0 means nothing to forward
    typedef struct packed {
        logic [4:0]  addr;
        logic [31:0] data;
    } fwdT;

    function automatic instrClassT instrClassOf(instrT instr);
        case (instr)
            iAdd, iSub, iAddu, iSubu, iAnd, iOr, iXor, iNor, iSlt, iSltu,
            iSll, iSllv, iSrl, iSrlv, iSra, iSrav, iMovz, iMovn, iClo, iClz:
                return calcR;
            iAddi, iAddiu, iAndi, iOri, iXori, iLui, iSlti, iSltiu:
                return calcI;
            iLw, iLh, iLhu, iLb, iLbu:
                return memRead;
            iSw, iSh, iSb:
                return memWrite;
            iBeq, iBne, iBlez, iBgtz, iBgez, iBltz, iBgezal, iBltzal:
                return branch;
            iJ, iJal, iJr, iJalr:
                return jump;
            default:
                return other;
        endcase
    endfunction

endpackage

// File: nextPcUnit.sv
`timescale 1ns/1ps

module nextPcUnit import mipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        stall,
    input  instrT       instr,
    input  logic        cmp,
    input  logic [15:0] imm16,
    input  logic [25:0] jIndex,
    input  logic [31:0] jmpReg,
    output logic [31:0] pcIf,
    output logic [31:0] pcId,
    output logic        excAdEL
);

    logic [31:0] pcPlus4;
    logic [31:0] branchOff;
    logic [31:0] pcNext;
    logic        isJr;

    // Targets are relative to the delay slot
    assign pcPlus4   = pcId + 32'd4;
    assign branchOff = {{14{imm16[15]}}, imm16, 2'b00};
    assign isJr      = (instr == iJr) || (instr == iJalr);

    always_comb begin
        if (instrClassOf(instr) == branch && cmp)
            pcNext = pcPlus4 + branchOff;
        else if (instr == iJ || instr == iJal)
            pcNext = {pcPlus4[31:28], jIndex, 2'b00};
        else if (isJr)
            pcNext = jmpReg;
        else
            pcNext = pcIf + 32'd4;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pcIf <= resetPc;
            pcId <= resetPc - 32'd4;
        end else if (!stall) begin
            pcId <= pcIf;
            pcIf <= pcNext;
        end
    end

    // Register target must be word aligned
    assign excAdEL = isJr && (jmpReg[1:0] != 2'b00);

endmodule

// File: regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    // Registers 1..31, zero is not stored
    logic [31:1][31:0] regs;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regs <= '0;
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // Same-cycle write shows up on the read side
    always_comb begin
        if (ra1 == 5'd0)
            rd1 = 32'd0;
        else if (we && wa == ra1)
            rd1 = wd;
        else
            rd1 = regs[ra1];
    end

    always_comb begin
        if (ra2 == 5'd0)
            rd2 = 32'd0;
        else if (we && wa == ra2)
            rd2 = wd;
        else
            rd2 = regs[ra2];
    end

    zeroRegReadsZero: assert property (
        @(posedge clk) ((ra1 == 5'd0) |-> (rd1 == 32'd0)) and ((ra2 == 5'd0) |-> (rd2 == 32'd0))
    ) else $error("register 0 read non-zero");

endmodule

// File: src.f
mipsPkg.sv
instrDecoder.sv
branchCompare.sv
regFile.sv
nextPcUnit.sv
idStage.sv
decodeTop.sv
tbDecodeTop.sv

// File: tbDecodeTop.sv
`timescale 1ns/1ps

module tbDecodeTop import mipsPkg::*; ();

    logic              clk = 1'b0;
    logic              rstN;
    logic              stall;
    logic              flush;
    instrWordT         code;
    fwdT               fwdEx;
    fwdT               fwdMem;
    logic              wbEn;
    logic [4:0]        wbAddr;
    logic [31:0]       wbData;
    logic [tWidth-1:0] tNewIn;
    logic [31:0]       pcIf;
    idExT              idEx;

    // ROM image with the expected symbol and destination kind of each word
    // Destination kind: 0 none, 1 rd, 2 rt
    logic [31:0] romWord [128];
    instrT       romSym [128];
    logic [1:0]  romDest [128];
    int          progLen;

    instrT       codeSym;
    logic [1:0]  codeDest;
    logic [31:0] shadow [32];
    logic [31:0] mPcIf;
    logic [31:0] mPcId;
    idExT        expIdEx;
    idExT        lastIdEx;
    logic [31:0] lastPcIf;
    int          cycleCount;
    int unsigned seedInit;

    always #4 clk = ~clk;

    decodeTop u_dut (
        .clk    (clk),
        .rstN   (rstN),
        .stall  (stall),
        .flush  (flush),
        .code   (code),
        .fwdEx  (fwdEx),
        .fwdMem (fwdMem),
        .wbEn   (wbEn),
        .wbAddr (wbAddr),
        .wbData (wbData),
        .tNewIn (tNewIn),
        .pcIf   (pcIf),
        .idEx   (idEx)
    );

    task automatic stopOnFailure();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string testName, input logic [63:0] expVal,
                                  input logic [63:0] actVal);
        $display("ERR %s expected %0h actual %0h", testName, expVal, actVal);
        stopOnFailure();
    endtask

    function automatic logic [31:0] rWord(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                          logic [4:0] rd, logic [4:0] sh, logic [5:0] fn);
        return {op, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iWord(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic addInstr(input logic [31:0] word, input instrT sym, input logic [1:0] dest);
        romWord[progLen] = word;
        romSym[progLen]  = sym;
        romDest[progLen] = dest;
        progLen++;
    endtask

    // Small value pool so that compares, jumps and sign tests hit both ways
    function automatic logic [31:0] pickData();
        case ($urandom % 6)
            0:       return 32'd0;
            1:       return 32'h0000_3040;
            2:       return 32'h0000_3042;
            3:       return 32'h8000_0000;
            default: return $urandom;
        endcase
    endfunction

    task automatic loadRom();
        logic [5:0] op;
        progLen = 0;
        addInstr(rWord(6'h00, 1, 2, 3, 0, 6'h21), iAddu, 2'd1);
        addInstr(iWord(6'h0f, 0, 2, 16'h3040), iLui, 2'd2);
        addInstr(iWord(6'h0d, 2, 1, 16'h00ff), iOri, 2'd2);
        addInstr(rWord(6'h00, 0, 2, 3, 5, 6'h00), iSll, 2'd1);
        addInstr(32'h0, iNop, 2'd0);
        addInstr(iWord(6'h04, 1, 2, 16'h0002), iBeq, 2'd0);
        addInstr(iWord(6'h05, 1, 3, 16'h0001), iBne, 2'd0);
        addInstr(iWord(6'h01, 2, 5'h00, 16'h0003), iBltz, 2'd0);
        addInstr(iWord(6'h01, 1, 5'h11, 16'h0001), iBgezal, 2'd0);
        addInstr(rWord(6'h00, 1, 2, 3, 0, 6'h0a), iMovz, 2'd0);
        addInstr(rWord(6'h00, 1, 2, 3, 0, 6'h0b), iMovn, 2'd0);
        addInstr({6'h03, 26'h000_0c14}, iJal, 2'd0);
        addInstr(iWord(6'h23, 1, 2, 16'h0008), iLw, 2'd2);
        addInstr(iWord(6'h2b, 1, 2, 16'h0004), iSw, 2'd0);
        addInstr(rWord(6'h00, 1, 2, 0, 0, 6'h18), iMult, 2'd0);
        addInstr(rWord(6'h00, 0, 0, 3, 0, 6'h12), iMflo, 2'd1);
        addInstr(iWord(6'h01, 2, 5'h10, 16'h0002), iBltzal, 2'd0);
        addInstr(rWord(6'h00, 2, 0, 3, 0, 6'h09), iJalr, 2'd1);
        addInstr(rWord(6'h10, 0, 2, 3, 0, 6'h00), iMfc0, 2'd0);
        addInstr(rWord(6'h1c, 1, 0, 3, 0, 6'h20), iClz, 2'd1);
        addInstr(rWord(6'h00, 2, 3, 1, 0, 6'h22), iSub, 2'd1);
        addInstr(iWord(6'h0a, 1, 2, 16'hffff), iSlti, 2'd2);
        addInstr(iWord(6'h07, 1, 0, 16'h0002), iBgtz, 2'd0);
        addInstr(iWord(6'h06, 2, 0, 16'h0001), iBlez, 2'd0);
        addInstr(rWord(6'h00, 1, 0, 0, 0, 6'h08), iJr, 2'd0);
        addInstr(iWord(6'h09, 1, 3, 16'h0004), iAddiu, 2'd2);
        addInstr(32'h4200_0018, iEret, 2'd0);
        addInstr(rWord(6'h00, 3, 2, 1, 0, 6'h07), iSrav, 2'd1);
        addInstr(iWord(6'h0e, 3, 3, 16'h5a5a), iXori, 2'd2);
        // Jump into the random region at 0x3100
        addInstr({6'h02, 26'h000_0c40}, iJ, 2'd0);
        addInstr(32'h0, iNop, 2'd0);
        // Unassigned opcodes with random bodies
        while (progLen < 128) begin
            case ($urandom % 4)
                0:       op = 6'h3f;
                1:       op = 6'h13;
                2:       op = 6'h1f;
                default: op = 6'h30;
            endcase
            addInstr({op, 26'($urandom)}, iNop, 2'd0);
        end
    endtask

    task automatic driveCycle();
        stall       <= ($urandom % 10) == 0;
        flush       <= ($urandom % 16) == 0;
        fwdEx.addr  <= 5'($urandom % 6);
        fwdEx.data  <= pickData();
        fwdMem.addr <= 5'($urandom % 6);
        fwdMem.data <= pickData();
        wbEn        <= 1'($urandom);
        wbAddr      <= 5'($urandom % 4);
        wbData      <= pickData();
        tNewIn      <= tWidth'($urandom);
    endtask

    // EX, then MEM, then register write-through, then the shadow copy
    function automatic logic [31:0] refOperand(logic [4:0] addr);
        if (fwdEx.addr != 5'd0 && fwdEx.addr == addr)
            return fwdEx.data;
        if (fwdMem.addr != 5'd0 && fwdMem.addr == addr)
            return fwdMem.data;
        if (addr == 5'd0)
            return 32'd0;
        if (wbEn && wbAddr == addr)
            return wbData;
        return shadow[addr];
    endfunction

    function automatic logic refCond(instrT sym, logic [31:0] a, logic [31:0] b);
        case (sym)
            iBeq:           return a == b;
            iBne:           return a != b;
            iBgez, iBgezal: return !a[31];
            iBltz, iBltzal: return a[31];
            iBgtz:          return $signed(a) > 0;
            iBlez:          return $signed(a) <= 0;
            iMovz:          return b == 32'd0;
            iMovn:          return b != 32'd0;
            default:        return 1'b0;
        endcase
    endfunction

    // Word in decode, one entry behind the fetch address
    always @(posedge clk) begin
        if (!rstN) begin
            code     <= '0;
            codeSym  <= iNop;
            codeDest <= 2'd0;
        end else if (!stall) begin
            code     <= romWord[pcIf[8:2]];
            codeSym  <= romSym[pcIf[8:2]];
            codeDest <= romDest[pcIf[8:2]];
        end
    end

    always @(posedge clk) begin : refModel
        logic [31:0] opRs;
        logic [31:0] opRt;
        logic [31:0] pcPlus4;
        logic [31:0] target;
        logic        taken;
        idExT        nxt;
        opRs    = refOperand(code.rView.rs);
        opRt    = refOperand(code.rView.rt);
        taken   = refCond(codeSym, opRs, opRt);
        pcPlus4 = mPcId + 32'd4;
        if (taken && !(codeSym inside {iMovz, iMovn}))
            target = pcPlus4 + {{14{code.iView.imm16[15]}}, code.iView.imm16, 2'b00};
        else if (codeSym inside {iJ, iJal})
            target = {pcPlus4[31:28], code[25:0], 2'b00};
        else if (codeSym inside {iJr, iJalr})
            target = opRs;
        else
            target = mPcIf + 32'd4;

        nxt        = '0;
        nxt.instr  = codeSym;
        nxt.pc     = mPcId;
        if (codeSym == iNop && code != 32'd0)
            nxt.exc = excRI;
        else if (codeSym inside {iJr, iJalr} && opRs[1:0] != 2'b00)
            nxt.exc = excAdEL;
        else
            nxt.exc = excNone;
        nxt.dataRs = opRs;
        nxt.dataRt = opRt;
        nxt.imm16  = code[15:0];
        nxt.shamt  = code[10:6];
        nxt.addrRs = code[25:21];
        nxt.addrRt = code[20:16];
        nxt.addrRd = code[15:11];
        if (codeSym == iJal)
            nxt.wbAddr = regLink;
        else if (codeSym inside {iBgezal, iBltzal})
            nxt.wbAddr = taken ? regLink : 5'd0;
        else if (codeSym inside {iMovz, iMovn})
            nxt.wbAddr = taken ? code[15:11] : 5'd0;
        else if (codeDest == 2'd1)
            nxt.wbAddr = code[15:11];
        else if (codeDest == 2'd2)
            nxt.wbAddr = code[20:16];
        if (codeSym inside {iJal, iJalr, iBgezal, iBltzal})
            nxt.wbData = mPcId + 32'd8;
        else if (codeSym == iLui)
            nxt.wbData = {code[15:0], 16'h0000};
        else if (codeSym inside {iMovz, iMovn} && taken)
            nxt.wbData = opRs;
        nxt.tNew = (tNewIn == '0) ? '0 : tNewIn - 1'b1;

        lastIdEx <= idEx;
        lastPcIf <= pcIf;
        if (!rstN) begin
            mPcIf <= resetPc;
            mPcId <= resetPc - 32'd4;
            for (int i = 0; i < 32; i++)
                shadow[i] <= 32'd0;
        end else begin
            if (!stall) begin
                mPcId <= mPcIf;
                mPcIf <= target;
            end
            if (wbEn && wbAddr != 5'd0)
                shadow[wbAddr] <= wbData;
        end
        if (!rstN || flush)
            expIdEx <= '0;
        else if (!stall)
            expIdEx <= nxt;
    end

    chkInstr: assert property (@(posedge clk) disable iff (!rstN)
        idEx.instr == expIdEx.instr)
        else reportMismatch("chkInstr", $sampled(expIdEx.instr), $sampled(idEx.instr));

    chkExc: assert property (@(posedge clk) disable iff (!rstN)
        idEx.exc == expIdEx.exc)
        else reportMismatch("chkExc", $sampled(expIdEx.exc), $sampled(idEx.exc));

    chkFields: assert property (@(posedge clk) disable iff (!rstN)
        {idEx.addrRs, idEx.addrRt, idEx.addrRd, idEx.imm16, idEx.shamt} ==
        {expIdEx.addrRs, expIdEx.addrRt, expIdEx.addrRd, expIdEx.imm16, expIdEx.shamt})
        else reportMismatch("chkFields",
            $sampled({expIdEx.addrRs, expIdEx.addrRt, expIdEx.addrRd, expIdEx.imm16,
                      expIdEx.shamt}),
            $sampled({idEx.addrRs, idEx.addrRt, idEx.addrRd, idEx.imm16, idEx.shamt}));

    chkOperands: assert property (@(posedge clk) disable iff (!rstN)
        {idEx.dataRs, idEx.dataRt} == {expIdEx.dataRs, expIdEx.dataRt})
        else reportMismatch("chkOperands", $sampled({expIdEx.dataRs, expIdEx.dataRt}),
                            $sampled({idEx.dataRs, idEx.dataRt}));

    chkWriteBack: assert property (@(posedge clk) disable iff (!rstN)
        {idEx.wbAddr, idEx.wbData} == {expIdEx.wbAddr, expIdEx.wbData})
        else reportMismatch("chkWriteBack", $sampled({expIdEx.wbAddr, expIdEx.wbData}),
                            $sampled({idEx.wbAddr, idEx.wbData}));

    chkPcTNew: assert property (@(posedge clk) disable iff (!rstN)
        {idEx.pc, idEx.tNew} == {expIdEx.pc, expIdEx.tNew})
        else reportMismatch("chkPcTNew", $sampled({expIdEx.pc, expIdEx.tNew}),
                            $sampled({idEx.pc, idEx.tNew}));

    chkFetch: assert property (@(posedge clk) disable iff (!rstN) pcIf == mPcIf)
        else reportMismatch("chkFetch", $sampled(mPcIf), $sampled(pcIf));

    chkStall: assert property (@(posedge clk) disable iff (!rstN)
        (stall && !flush) |=> (idEx == lastIdEx && pcIf == lastPcIf))
        else reportMismatch("chkStall", $sampled({lastIdEx.pc, lastPcIf}),
                            $sampled({idEx.pc, pcIf}));

    chkFlush: assert property (@(posedge clk) disable iff (!rstN) flush |=> idEx == '0)
        else reportMismatch("chkFlush", 64'd0, $sampled({idEx.instr, idEx.pc}));

    chkReset: assert property (@(posedge clk)
        $rose(rstN) |-> (pcIf == resetPc && idEx.instr == iNop))
        else reportMismatch("chkReset", {32'd0, resetPc}, $sampled({idEx.instr, pcIf}));

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= 400) begin
            $display("timeout: program did not finish");
            stopOnFailure();
        end
    end

    initial begin
        seedInit   = $urandom(32'h15ca_d5ea);
        rstN       = 1'b0;
        stall      = 1'b0;
        flush      = 1'b0;
        code       = '0;
        codeSym    = iNop;
        codeDest   = 2'd0;
        fwdEx      = '0;
        fwdMem     = '0;
        wbEn       = 1'b0;
        wbAddr     = 5'd0;
        wbData     = 32'd0;
        tNewIn     = '0;
        cycleCount = 0;
        loadRom();
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        // Two passes over the program and the random region
        repeat (300) begin
            @(posedge clk);
            driveCycle();
        end
        repeat (2) @(posedge clk);
        $display("Test passed");
        $finish;
    end

endmodule
